/* hdl/bus_pkg.sv */
package bus_pkg;
  localparam int NUM_SLAVES = 3;
  localparam int CMD_DEPTH  = 2;
  localparam int DATA_DEPTH = 4;

  typedef enum logic [1:0] {
    CMD_READ     = 2'd0,  // Non-posted, no data.
    CMD_WRITE    = 2'd1,  // Posted, with data.
    CMD_WRITE_NP = 2'd2   // Non-posted, with data.
  } cmd_e;

  typedef logic [3:0]  id_t;
  typedef logic [15:0] addr_t;
  typedef logic [3:0]  len_t;  // Beats minus one.
  typedef logic [31:0] data_t;

  // FIFO pointer and occupancy widths.
  typedef logic [$clog2(CMD_DEPTH)-1:0]    cmd_ptr_t;
  typedef logic [$clog2(CMD_DEPTH+1)-1:0]  cmd_cnt_t;
  typedef logic [$clog2(DATA_DEPTH)-1:0]   data_ptr_t;
  typedef logic [$clog2(DATA_DEPTH+1)-1:0] data_cnt_t;

  function automatic logic has_data(cmd_e cmd);
    return cmd != CMD_READ;
  endfunction

  function automatic logic is_non_posted(cmd_e cmd);
    return cmd != CMD_WRITE;
  endfunction
endpackage

/* hdl/arb_pkg.sv */
package arb_pkg;
  localparam int PTR_WIDTH = 2;

  // One bit per slave; also used for one-hot grants and selects.
  typedef logic [bus_pkg::NUM_SLAVES-1:0] req_t;

  typedef logic [PTR_WIDTH-1:0] ptr_t;  // Last winner index.
endpackage

/* hdl/request_fifo.sv */
module request_fifo (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_cmd_valid,
  input  bus_pkg::cmd_e   i_cmd,
  input  bus_pkg::id_t    i_id,
  input  bus_pkg::addr_t  i_addr,
  input  bus_pkg::len_t   i_len,
  output logic            o_cmd_accept,
  input  logic            i_data_valid,
  input  bus_pkg::data_t  i_data,
  input  logic            i_data_last,
  output logic            o_data_accept,
  output logic            o_cmd_valid,
  output bus_pkg::cmd_e   o_cmd,
  output bus_pkg::id_t    o_id,
  output bus_pkg::addr_t  o_addr,
  output bus_pkg::len_t   o_len,
  input  logic            i_cmd_ready,
  output logic            o_data_valid,
  output bus_pkg::data_t  o_data,
  output logic            o_data_last,
  input  logic            i_data_ready
);
  bus_pkg::cmd_e      cmd_mem  [bus_pkg::CMD_DEPTH];
  bus_pkg::id_t       id_mem   [bus_pkg::CMD_DEPTH];
  bus_pkg::addr_t     addr_mem [bus_pkg::CMD_DEPTH];
  bus_pkg::len_t      len_mem  [bus_pkg::CMD_DEPTH];
  bus_pkg::data_t     data_mem [bus_pkg::DATA_DEPTH];
  logic               last_mem [bus_pkg::DATA_DEPTH];
  bus_pkg::cmd_ptr_t  cmd_wptr;
  bus_pkg::cmd_ptr_t  cmd_rptr;
  bus_pkg::cmd_cnt_t  cmd_count;
  bus_pkg::data_ptr_t data_wptr;
  bus_pkg::data_ptr_t data_rptr;
  bus_pkg::data_cnt_t data_count;
  logic               cmd_push;
  logic               cmd_pop;
  logic               data_push;
  logic               data_pop;

  assign o_cmd_accept  = i_cmd_valid && (cmd_count != bus_pkg::cmd_cnt_t'(bus_pkg::CMD_DEPTH));
  assign o_data_accept = i_data_valid &&
                         (data_count != bus_pkg::data_cnt_t'(bus_pkg::DATA_DEPTH));
  assign o_cmd_valid   = cmd_count != '0;
  assign o_data_valid  = data_count != '0;

  assign cmd_push  = i_cmd_valid && o_cmd_accept;
  assign cmd_pop   = o_cmd_valid && i_cmd_ready;
  assign data_push = i_data_valid && o_data_accept;
  assign data_pop  = o_data_valid && i_data_ready;

  assign o_cmd       = cmd_mem[cmd_rptr];  // Head of queue.
  assign o_id        = id_mem[cmd_rptr];
  assign o_addr      = addr_mem[cmd_rptr];
  assign o_len       = len_mem[cmd_rptr];
  assign o_data      = data_mem[data_rptr];
  assign o_data_last = last_mem[data_rptr];

  always_ff @(posedge i_clk) begin
    if (cmd_push) begin
      cmd_mem[cmd_wptr]  <= i_cmd;
      id_mem[cmd_wptr]   <= i_id;
      addr_mem[cmd_wptr] <= i_addr;
      len_mem[cmd_wptr]  <= i_len;
    end
    if (data_push) begin
      data_mem[data_wptr] <= i_data;
      last_mem[data_wptr] <= i_data_last;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_wptr  <= '0;
      cmd_rptr  <= '0;
      cmd_count <= '0;
    end else begin
      if (cmd_push) begin
        cmd_wptr <= (cmd_wptr == bus_pkg::cmd_ptr_t'(bus_pkg::CMD_DEPTH - 1)) ?
                    '0 : cmd_wptr + 1'b1;
      end
      if (cmd_pop) begin
        cmd_rptr <= (cmd_rptr == bus_pkg::cmd_ptr_t'(bus_pkg::CMD_DEPTH - 1)) ?
                    '0 : cmd_rptr + 1'b1;
      end
      case ({cmd_push, cmd_pop})
        2'b10:   cmd_count <= cmd_count + 1'b1;
        2'b01:   cmd_count <= cmd_count - 1'b1;
        default: cmd_count <= cmd_count;  // Idle or push with pop.
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_wptr  <= '0;
      data_rptr  <= '0;
      data_count <= '0;
    end else begin
      if (data_push) begin
        data_wptr <= (data_wptr == bus_pkg::data_ptr_t'(bus_pkg::DATA_DEPTH - 1)) ?
                     '0 : data_wptr + 1'b1;
      end
      if (data_pop) begin
        data_rptr <= (data_rptr == bus_pkg::data_ptr_t'(bus_pkg::DATA_DEPTH - 1)) ?
                     '0 : data_rptr + 1'b1;
      end
      case ({data_push, data_pop})
        2'b10:   data_count <= data_count + 1'b1;
        2'b01:   data_count <= data_count - 1'b1;
        default: data_count <= data_count;
      endcase
    end
  end
endmodule

/* hdl/rr_arbiter.sv */
module rr_arbiter (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  arb_pkg::req_t i_request,
  input  logic          i_free,
  output arb_pkg::req_t o_grant
);
  arb_pkg::req_t held_q;
  arb_pkg::req_t search_grant;
  arb_pkg::ptr_t last_q;
  arb_pkg::ptr_t win_idx;

  // Rotating priority, starting just after the last winner.
  always_comb begin : search
    int idx;
    search_grant = '0;
    for (int k = 1; k <= bus_pkg::NUM_SLAVES; k++) begin
      idx = (int'(last_q) + k) % bus_pkg::NUM_SLAVES;
      if ((search_grant == '0) && i_request[idx]) begin
        search_grant[idx] = 1'b1;
      end
    end
  end

  assign o_grant = (held_q != '0) ? held_q : search_grant;  // Locked result wins.

  always_comb begin
    win_idx = last_q;
    for (int k = 0; k < bus_pkg::NUM_SLAVES; k++) begin
      if (o_grant[k]) begin
        win_idx = arb_pkg::ptr_t'(k);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      held_q <= '0;
      last_q <= arb_pkg::ptr_t'(bus_pkg::NUM_SLAVES - 1);  // Slave 0 wins first.
    end else if (i_free) begin
      held_q <= '0;
      last_q <= win_idx;
    end else if (held_q == '0) begin
      held_q <= search_grant;  // Lock a fresh grant.
    end
  end
endmodule

/* hdl/request_switch.sv */
module request_switch (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_mcmd_valid  [bus_pkg::NUM_SLAVES],
  input  bus_pkg::cmd_e   i_mcmd        [bus_pkg::NUM_SLAVES],
  input  bus_pkg::id_t    i_mid         [bus_pkg::NUM_SLAVES],
  input  bus_pkg::addr_t  i_maddr       [bus_pkg::NUM_SLAVES],
  input  bus_pkg::len_t   i_mlen        [bus_pkg::NUM_SLAVES],
  output logic            o_scmd_accept [bus_pkg::NUM_SLAVES],
  input  logic            i_mdata_valid [bus_pkg::NUM_SLAVES],
  input  bus_pkg::data_t  i_mdata       [bus_pkg::NUM_SLAVES],
  input  logic            i_mdata_last  [bus_pkg::NUM_SLAVES],
  output logic            o_sdata_accept[bus_pkg::NUM_SLAVES],
  output logic            o_mcmd_valid,
  output bus_pkg::cmd_e   o_mcmd,
  output bus_pkg::id_t    o_mid,
  output bus_pkg::addr_t  o_maddr,
  output bus_pkg::len_t   o_mlen,
  input  logic            i_scmd_accept,
  output logic            o_mdata_valid,
  output bus_pkg::data_t  o_mdata,
  output logic            o_mdata_last,
  input  logic            i_sdata_accept,
  output arb_pkg::req_t   o_response_select,
  input  logic            i_response_ack
);
  logic           f_cmd_valid  [bus_pkg::NUM_SLAVES];
  bus_pkg::cmd_e  f_cmd        [bus_pkg::NUM_SLAVES];
  bus_pkg::id_t   f_id         [bus_pkg::NUM_SLAVES];
  bus_pkg::addr_t f_addr       [bus_pkg::NUM_SLAVES];
  bus_pkg::len_t  f_len        [bus_pkg::NUM_SLAVES];
  logic           f_cmd_ready  [bus_pkg::NUM_SLAVES];
  logic           f_data_valid [bus_pkg::NUM_SLAVES];
  bus_pkg::data_t f_data       [bus_pkg::NUM_SLAVES];
  logic           f_data_last  [bus_pkg::NUM_SLAVES];
  logic           f_data_ready [bus_pkg::NUM_SLAVES];
  arb_pkg::req_t  request;
  arb_pkg::req_t  grant;
  logic           free;
  logic           response_idle;
  logic           cmd_done_q;
  logic           data_done_q;
  logic           cmd_open;
  logic           data_open;
  logic           sel_cmd_valid;
  logic           sel_data_valid;
  logic           cmd_ack;
  logic           cmd_data_ack;
  logic           data_last_ack;

  for (genvar g = 0; g < bus_pkg::NUM_SLAVES; g++) begin : g_slave
    request_fifo i_request_fifo (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_cmd_valid   (i_mcmd_valid[g]),
      .i_cmd         (i_mcmd[g]),
      .i_id          (i_mid[g]),
      .i_addr        (i_maddr[g]),
      .i_len         (i_mlen[g]),
      .o_cmd_accept  (o_scmd_accept[g]),
      .i_data_valid  (i_mdata_valid[g]),
      .i_data        (i_mdata[g]),
      .i_data_last   (i_mdata_last[g]),
      .o_data_accept (o_sdata_accept[g]),
      .o_cmd_valid   (f_cmd_valid[g]),
      .o_cmd         (f_cmd[g]),
      .o_id          (f_id[g]),
      .o_addr        (f_addr[g]),
      .o_len         (f_len[g]),
      .i_cmd_ready   (f_cmd_ready[g]),
      .o_data_valid  (f_data_valid[g]),
      .o_data        (f_data[g]),
      .o_data_last   (f_data_last[g]),
      .i_data_ready  (f_data_ready[g])
    );

    assign request[g]      = f_cmd_valid[g] && response_idle;  // Masked while waiting.
    assign f_cmd_ready[g]  = grant[g] && cmd_open && i_scmd_accept;
    assign f_data_ready[g] = grant[g] && data_open && i_sdata_accept;
  end

  rr_arbiter i_rr_arbiter (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_request (request),
    .i_free    (free),
    .o_grant   (grant)
  );

  // One-hot mux of the granted FIFO heads.
  always_comb begin
    sel_cmd_valid  = 1'b0;
    sel_data_valid = 1'b0;
    o_mcmd         = bus_pkg::CMD_READ;
    o_mid          = '0;
    o_maddr        = '0;
    o_mlen         = '0;
    o_mdata        = '0;
    o_mdata_last   = 1'b0;
    for (int i = 0; i < bus_pkg::NUM_SLAVES; i++) begin
      if (grant[i]) begin
        sel_cmd_valid  = f_cmd_valid[i];
        sel_data_valid = f_data_valid[i];
        o_mcmd         = f_cmd[i];
        o_mid          = f_id[i];
        o_maddr        = f_addr[i];
        o_mlen         = f_len[i];
        o_mdata        = f_data[i];
        o_mdata_last   = f_data_last[i];
      end
    end
  end

  // One command per access, and data only for an access that carries it.
  assign cmd_open  = response_idle && !cmd_done_q;
  assign data_open = !data_done_q &&
                     (cmd_done_q || (sel_cmd_valid && bus_pkg::has_data(o_mcmd)));

  assign o_mcmd_valid  = sel_cmd_valid && cmd_open;
  assign o_mdata_valid = sel_data_valid && data_open;

  assign cmd_ack       = o_mcmd_valid && i_scmd_accept;
  assign cmd_data_ack  = cmd_ack && bus_pkg::has_data(o_mcmd);
  assign data_last_ack = o_mdata_valid && i_sdata_accept && o_mdata_last;

  assign free = (cmd_ack && !bus_pkg::has_data(o_mcmd)) ||
                (cmd_data_ack && (data_last_ack || data_done_q)) ||
                (data_last_ack && cmd_done_q);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_done_q  <= 1'b0;
      data_done_q <= 1'b0;
    end else if (free) begin
      cmd_done_q  <= 1'b0;
      data_done_q <= 1'b0;
    end else begin
      if (cmd_data_ack) begin
        cmd_done_q <= 1'b1;  // Waiting for the last beat.
      end
      if (data_last_ack) begin
        data_done_q <= 1'b1;  // Burst ran ahead of its command.
      end
    end
  end

  assign response_idle = o_response_select == '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_response_select <= '0;
    end else if (i_response_ack) begin
      o_response_select <= '0;
    end else if (cmd_ack && bus_pkg::is_non_posted(o_mcmd)) begin
      o_response_select <= grant;
    end
  end
endmodule

/* verif/request_switch_sva.sv */
module request_switch_sva (
  input logic           i_clk,
  input logic           i_rst_n,
  input logic           i_mcmd_valid,
  input bus_pkg::cmd_e  i_mcmd,
  input bus_pkg::id_t   i_mid,
  input bus_pkg::addr_t i_maddr,
  input bus_pkg::len_t  i_mlen,
  input logic           i_scmd_accept,
  input arb_pkg::req_t  i_response_select
);
  timeunit 1ns;
  timeprecision 1ps;

  property p_cmd_held;
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_mcmd_valid && !i_scmd_accept) |=>
        (i_mcmd_valid && $stable({i_mcmd, i_mid, i_maddr, i_mlen}));
  endproperty

  a_cmd_held : assert property (p_cmd_held)
    else $error("Master command dropped or changed before accept.");

  a_select_onehot : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) $onehot0(i_response_select))
    else $error("Response select has more than one bit set.");

  // No new command may leave while a response is outstanding.
  a_blocked_while_waiting : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (i_response_select != '0) |-> !i_mcmd_valid)
    else $error("Master command valid while a response is outstanding.");
endmodule

bind request_switch request_switch_sva i_request_switch_sva (
  .i_clk             (i_clk),
  .i_rst_n           (i_rst_n),
  .i_mcmd_valid      (o_mcmd_valid),
  .i_mcmd            (o_mcmd),
  .i_mid             (o_mid),
  .i_maddr           (o_maddr),
  .i_mlen            (o_mlen),
  .i_scmd_accept     (i_scmd_accept),
  .i_response_select (o_response_select)
);

/* verif/tb_request_switch.sv */
module tb_request_switch;
  timeunit 1ns;
  timeprecision 1ps;

  logic           i_clk;
  logic           i_rst_n;
  logic           i_mcmd_valid  [bus_pkg::NUM_SLAVES];
  bus_pkg::cmd_e  i_mcmd        [bus_pkg::NUM_SLAVES];
  bus_pkg::id_t   i_mid         [bus_pkg::NUM_SLAVES];
  bus_pkg::addr_t i_maddr       [bus_pkg::NUM_SLAVES];
  bus_pkg::len_t  i_mlen        [bus_pkg::NUM_SLAVES];
  logic           o_scmd_accept [bus_pkg::NUM_SLAVES];
  logic           i_mdata_valid [bus_pkg::NUM_SLAVES];
  bus_pkg::data_t i_mdata       [bus_pkg::NUM_SLAVES];
  logic           i_mdata_last  [bus_pkg::NUM_SLAVES];
  logic           o_sdata_accept[bus_pkg::NUM_SLAVES];
  logic           o_mcmd_valid;
  bus_pkg::cmd_e  o_mcmd;
  bus_pkg::id_t   o_mid;
  bus_pkg::addr_t o_maddr;
  bus_pkg::len_t  o_mlen;
  logic           i_scmd_accept;
  logic           o_mdata_valid;
  bus_pkg::data_t o_mdata;
  logic           o_mdata_last;
  logic           i_sdata_accept;
  arb_pkg::req_t  o_response_select;
  logic           i_response_ack;

  logic [25:0] cmd_q    [bus_pkg::NUM_SLAVES][$];  // {cmd, id, addr, len}.
  logic [32:0] data_q   [bus_pkg::NUM_SLAVES][$];  // {last, data}.
  logic [25:0] exp_cmd  [bus_pkg::NUM_SLAVES][$];
  logic [32:0] exp_data [bus_pkg::NUM_SLAVES][$];
  logic [25:0] got_cmd  [$];
  logic [32:0] got_data [$];
  logic        cmd_fire [bus_pkg::NUM_SLAVES];
  logic        data_fire[bus_pkg::NUM_SLAVES];
  logic [25:0] cmd_entry;
  logic [32:0] data_entry;
  logic [15:0] rnd;
  logic [31:0] lcg_state;
  logic        resp_pending;
  logic        sel_seen;
  logic        stall_mode;
  logic        auto_ack;
  logic        ack_now;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_start = 0;
  int          n_cmd_exp = 0;
  int          n_data_exp = 0;

  request_switch i_request_switch (.*);

  always #20 i_clk = ~i_clk;

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // Sample handshakes mid-cycle, where every signal is settled.
  always @(negedge i_clk) begin
    for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
      cmd_fire[s]  = i_mcmd_valid[s] && o_scmd_accept[s];
      data_fire[s] = i_mdata_valid[s] && o_sdata_accept[s];
    end
    resp_pending = o_response_select != '0;
    if (resp_pending) begin
      sel_seen = 1'b1;
    end
    if (o_mcmd_valid && i_scmd_accept) begin
      got_cmd.push_back({o_mcmd, o_mid, o_maddr, o_mlen});
    end
    if (o_mdata_valid && i_sdata_accept) begin
      got_data.push_back({o_mdata_last, o_mdata});
    end
  end

  always @(posedge i_clk) begin
    rnd = lcg_next();
    i_scmd_accept  <= !stall_mode || rnd[3];
    i_sdata_accept <= !stall_mode || rnd[11];
    i_response_ack <= (auto_ack || ack_now) && resp_pending && !i_response_ack;
    for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
      if (i_rst_n && (!i_mcmd_valid[s] || cmd_fire[s])) begin
        i_mcmd_valid[s] <= cmd_q[s].size() != 0;
        if (cmd_q[s].size() != 0) begin
          cmd_entry  = cmd_q[s].pop_front();
          i_mcmd[s]  <= bus_pkg::cmd_e'(cmd_entry[25:24]);
          i_mid[s]   <= cmd_entry[23:20];
          i_maddr[s] <= cmd_entry[19:4];
          i_mlen[s]  <= cmd_entry[3:0];
        end
      end
      if (i_rst_n && (!i_mdata_valid[s] || data_fire[s])) begin
        i_mdata_valid[s] <= data_q[s].size() != 0;
        if (data_q[s].size() != 0) begin
          data_entry      = data_q[s].pop_front();
          i_mdata_last[s] <= data_entry[32];
          i_mdata[s]      <= data_entry[31:0];
        end
      end
    end
  end

  task automatic check(input string name, input logic [32:0] got, input logic [32:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Queue one access; the id and the data carry slave and access number.
  task automatic send(input int s, input bus_pkg::cmd_e kind, input int k,
                      input bus_pkg::len_t len);
    logic [25:0] c;
    logic [32:0] d;
    c = {kind, 2'(s), 2'(k), 4'(s + 1), 4'(k), 8'h40, len};
    cmd_q[s].push_back(c);
    exp_cmd[s].push_back(c);
    n_cmd_exp++;
    if (kind != bus_pkg::CMD_READ) begin
      for (int b = 0; b <= int'(len); b++) begin
        d = {b == int'(len), 8'(s), 8'(k), 16'(b)};
        data_q[s].push_back(d);
        exp_data[s].push_back(d);
        n_data_exp++;
      end
    end
  endtask

  task automatic wait_count(input int n_cmd, input int n_data);
    int cycles;
    cycles = 0;
    while ((got_cmd.size() < n_cmd || got_data.size() < n_data) && cycles < 3000) begin
      @(posedge i_clk);
      cycles++;
    end
    if (got_cmd.size() < n_cmd || got_data.size() < n_data) begin
      $display("Timeout: %0d of %0d commands and %0d of %0d beats arrived",
               got_cmd.size(), n_cmd, got_data.size(), n_data);
      errors++;
    end
    repeat (4) @(posedge i_clk);  // Room for any stray transfer.
  endtask

  task automatic wait_select(input logic want_set);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (((o_response_select != '0) != want_set) && cycles < 200) begin
      @(negedge i_clk);
      cycles++;
    end
    if ((o_response_select != '0) != want_set) begin
      $display("Timeout: o_response_select never became %s", want_set ? "set" : "zero");
      errors++;
    end
  endtask

  task automatic begin_test();
    err_start  = errors;
    n_cmd_exp  = 0;
    n_data_exp = 0;
    sel_seen   = 1'b0;
    got_cmd.delete();
    got_data.delete();
    for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
      exp_cmd[s].delete();
      exp_data[s].delete();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%-20s %s", name, (errors == err_start) ? "passed" : "failed");
  endtask

  // Everything sent arrives once, in order per slave.
  task automatic check_traffic();
    int s;
    foreach (got_cmd[i]) begin
      s = int'(got_cmd[i][23:22]);
      if (s >= bus_pkg::NUM_SLAVES || exp_cmd[s].size() == 0) begin
        $display("Unexpected master command %0h", got_cmd[i]);
        errors++;
      end else begin
        check("o_mcmd/o_mid/o_maddr/o_mlen", 33'(got_cmd[i]), 33'(exp_cmd[s].pop_front()));
      end
    end
    foreach (got_data[i]) begin
      s = int'(got_data[i][31:24]);
      if (s >= bus_pkg::NUM_SLAVES || exp_data[s].size() == 0) begin
        $display("Unexpected master data beat %0h", got_data[i]);
        errors++;
      end else begin
        check("o_mdata_last/o_mdata", got_data[i], exp_data[s].pop_front());
      end
    end
    for (int k = 0; k < bus_pkg::NUM_SLAVES; k++) begin
      if (exp_cmd[k].size() != 0 || exp_data[k].size() != 0) begin
        $display("Slave %0d lost %0d commands and %0d beats", k, exp_cmd[k].size(),
                 exp_data[k].size());
        errors++;
      end
    end
  endtask

  task automatic read_each_slave();
    begin_test();
    for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
      @(negedge i_clk);
      send(s, bus_pkg::CMD_READ, 1, 4'd2);
      wait_select(1'b1);
      check("o_response_select", 33'(o_response_select), 33'(1) << s);
      repeat (3) @(negedge i_clk);
      check("o_response_select held", 33'(o_response_select), 33'(1) << s);
      ack_now = 1'b1;
      wait_select(1'b0);
      ack_now = 1'b0;
    end
    wait_count(3, 0);
    check_traffic();
    end_test("read_each_slave");
  endtask

  task automatic round_robin_order();
    begin_test();
    @(negedge i_clk);
    for (int k = 0; k < 2; k++) begin
      for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
        send(s, bus_pkg::CMD_WRITE, k, 4'd0);
      end
    end
    wait_count(6, 6);
    foreach (got_cmd[i]) begin
      check("o_mid slave", 33'(got_cmd[i][23:22]), 33'(i % bus_pkg::NUM_SLAVES));
    end
    check_traffic();
    end_test("round_robin_order");
  endtask

  task automatic concurrent_bursts();
    begin_test();
    @(negedge i_clk);
    for (int k = 0; k < 2; k++) begin
      send(0, bus_pkg::CMD_WRITE, k, 4'd3);
      send(2, bus_pkg::CMD_WRITE, k, 4'd3);
    end
    wait_count(4, 16);
    // Slave 0 wins after slave 2, so the bursts alternate 0, 2, 0, 2.
    for (int g = 0; g < 4 && g < got_cmd.size(); g++) begin
      check("o_mid slave", 33'(got_cmd[g][23:22]), 33'((g % 2) * 2));
      for (int b = 0; b < 4 && 4 * g + b < got_data.size(); b++) begin
        check("o_mdata slave", 33'(got_data[4 * g + b][31:24]), 33'((g % 2) * 2));
        check("o_mdata access", 33'(got_data[4 * g + b][23:16]), 33'(g / 2));
      end
    end
    check_traffic();
    end_test("concurrent_bursts");
  endtask

  task automatic non_posted_block();
    begin_test();
    @(negedge i_clk);
    send(0, bus_pkg::CMD_WRITE_NP, 0, 4'd1);
    send(1, bus_pkg::CMD_WRITE, 0, 4'd0);
    send(2, bus_pkg::CMD_WRITE, 0, 4'd0);
    wait_select(1'b1);
    check("o_response_select", 33'(o_response_select), 33'(1));
    repeat (10) @(posedge i_clk);
    check("commands while blocked", 33'(got_cmd.size()), 33'(1));
    ack_now = 1'b1;
    wait_select(1'b0);
    ack_now = 1'b0;
    wait_count(3, 4);
    foreach (got_cmd[i]) begin
      check("o_mid slave", 33'(got_cmd[i][23:22]), 33'(i));
    end
    check_traffic();
    end_test("non_posted_block");
  endtask

  task automatic posted_burst();
    begin_test();
    @(negedge i_clk);
    send(1, bus_pkg::CMD_WRITE, 2, 4'd3);
    wait_count(1, 4);
    check("o_response_select seen", 33'(sel_seen), 33'(0));
    check_traffic();
    end_test("posted_burst");
  endtask

  task automatic random_stalls();
    logic [15:0]   r;
    bus_pkg::cmd_e kind;
    begin_test();
    @(negedge i_clk);
    stall_mode = 1'b1;
    auto_ack   = 1'b1;
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
        r    = lcg_next();
        kind = (r[1:0] == 2'd3) ? bus_pkg::CMD_WRITE : bus_pkg::cmd_e'(r[1:0]);
        send(s, kind, k, bus_pkg::len_t'(r[5:4]));
      end
    end
    wait_count(n_cmd_exp, n_data_exp);
    stall_mode = 1'b0;
    wait_select(1'b0);
    auto_ack = 1'b0;
    check_traffic();
    end_test("random_stalls");
  endtask

  initial begin
    i_clk          = 1'b0;
    i_rst_n        = 1'b0;
    i_scmd_accept  = 1'b1;
    i_sdata_accept = 1'b1;
    i_response_ack = 1'b0;
    for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
      i_mcmd_valid[s]  = 1'b0;
      i_mcmd[s]        = bus_pkg::CMD_READ;
      i_mid[s]         = '0;
      i_maddr[s]       = '0;
      i_mlen[s]        = '0;
      i_mdata_valid[s] = 1'b0;
      i_mdata[s]       = '0;
      i_mdata_last[s]  = 1'b0;
      cmd_fire[s]      = 1'b0;
      data_fire[s]     = 1'b0;
    end
    lcg_state    = 32'd65;
    resp_pending = 1'b0;
    sel_seen     = 1'b0;
    stall_mode   = 1'b0;
    auto_ack     = 1'b0;
    ack_now      = 1'b0;
    repeat (4) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(posedge i_clk);
    read_each_slave();
    round_robin_order();  // Starts with slave 2 as last winner.
    concurrent_bursts();
    non_posted_block();
    posted_burst();
    random_stalls();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule

/* vlog.f */
hdl/bus_pkg.sv
hdl/arb_pkg.sv
hdl/request_fifo.sv
hdl/rr_arbiter.sv
hdl/request_switch.sv
verif/request_switch_sva.sv
verif/tb_request_switch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_request_switch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
